//--- Makefile
VERILATOR ?= verilator
TOP       ?= kicker_game_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
source/kicker_pkg.sv
source/frac_cen.sv
source/rom_dwnld.sv
source/rom_arbiter.sv
source/video_scroll.sv
source/kicker_game.sv
dv/kicker_game_properties.sv
dv/kicker_game_tb.sv

//--- dv/kicker_game_properties.sv
// Concurrent checks on the SDRAM read and programming handshakes, bound into arbiter and download
module kicker_game_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        downloading,
    input logic        req,
    input logic [21:0] addr,
    input logic        ack,
    input logic        we
);

int failures = 0;   // Read back by the testbench

// Request and its address hold until the SDRAM takes them
req_stable: assert property (@(posedge clk) disable iff (!rst_n)
    req && !ack |=> req && $stable(addr))
    else begin
        $error("SDRAM request dropped or changed before ack");
        failures++;
    end

no_req_in_dwnld: assert property (@(posedge clk) disable iff (!rst_n)
    downloading |-> !req)
    else begin
        $error("SDRAM read request while downloading");
        failures++;
    end

// Write strobe ends right after the SDRAM ack
we_drop: assert property (@(posedge clk) disable iff (!rst_n)
    we && ack |=> !we)
    else begin
        $error("Programming write still high after ack");
        failures++;
    end

endmodule

//--- dv/kicker_game_tb.sv
// Testbench for the kicker game core that runs directed tests against a behavioral SDRAM model
module kicker_game_tb
    import kicker_pkg::*;
();

localparam int swab_cfg   = 1;
localparam int sd_lat     = 2;                  // Cycles to ack and again to rdy
localparam int line_clks  = 256 * 125 / 16;     // One video line at 16/125 pixel rate
localparam int check_line = 20;
localparam int max_cycles = (check_line + 2) * line_clks;   // Video test ends the run

logic        clk = 1'b0;
logic        rst_n;
logic        pxl_cen;
logic        pxl2_cen;
logic [8:0]  h_cnt;
logic [8:0]  v_cnt;
video_sync_t sync;
logic [3:0]  pxl;
logic        downloading;
logic        dwnld_busy;
logic [24:0] ioctl_addr;
logic [7:0]  ioctl_dout;
logic        ioctl_wr;
prog_t       prog;
logic        main_cs;
logic [16:0] main_addr;
logic [7:0]  main_data;
logic        main_ok;
sdram_rd_t   sdram;
sdram_rsp_t  rsp = '0;

logic [31:0] lfsr = 32'hf6ed2285;
logic [21:0] pend_addr;
logic        pend_rd = 1'b0;
int          ack_wait = 0;
int          rdy_wait = 0;
int          ack_count = 0;
int          req_count = 0;
int          errors = 0;
int          checks = 0;
int          tests = 0;
int          test_base = 0;
int          cycles = 0;
string       test_name;

kicker_game #(.swab(swab_cfg), .cen_n(16), .cen_m(125)) kicker_game_i (.*);

bind rom_arbiter kicker_game_properties arb_props (
    .clk(clk), .rst_n(rst_n), .downloading(downloading),
    .req(sdram.req), .addr(sdram.addr), .ack(rsp.ack), .we(1'b0)
);
bind rom_dwnld kicker_game_properties dwnld_props (
    .clk(clk), .rst_n(rst_n), .downloading(1'b0),
    .req(1'b0), .addr(22'd0), .ack(sdram_ack), .we(prog.we)
);

always #4 clk = ~clk;

// SDRAM model that acks reads and programming writes and returns read data
always @(negedge clk) begin
    rsp.ack <= 1'b0;
    rsp.rdy <= 1'b0;
    if (rdy_wait > 0) begin
        rdy_wait <= rdy_wait - 1;
        if (rdy_wait == 1) begin
            rsp.rdy  <= 1'b1;
            rsp.data <= model_word(pend_addr);
        end
    end
    if (ack_wait > 0) begin
        ack_wait <= ack_wait - 1;
        if (ack_wait == 1) begin
            rsp.ack   <= 1'b1;
            ack_count <= ack_count + 1;
            if (pend_rd) rdy_wait <= sd_lat;
        end
    end else if (rst_n && (sdram.req || prog.we)) begin
        ack_wait  <= sd_lat;
        pend_addr <= sdram.addr;
        pend_rd   <= sdram.req;
        req_count <= req_count + (sdram.req ? 1 : 0);
    end
end

function automatic logic [15:0] model_word(input logic [21:0] a);
    return a[15:0] ^ 16'h5a3c;
endfunction

// x^32 + x^22 + x^2 + x + 1
task automatic rand_bits(input int nbits, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < nbits; i++) begin
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        val  = {val[30:0], lfsr[0]};
    end
endtask

function automatic prog_t exp_prog(input logic [24:0] a, input logic [7:0] d);
    logic [21:0] w;
    logic [1:0]  lanes;
    w     = a[22:1];
    lanes = a[0] ? 2'b01 : 2'b10;   // Even bytes go to the low lane
    if (swab_cfg != 0) lanes = ~lanes;
    if (a > scr_start && a < scr_start + 25'h04000) w = {w[21:4], w[2:0], w[3]};
    return '{we: 1'b1, addr: w, data: d, mask: lanes};
endfunction

function automatic logic [7:0] exp_byte(input logic [16:0] a);
    logic [15:0] w;
    w = model_word({6'd0, a[16:1]});
    return a[0] ? w[15:8] : w[7:0];
endfunction

function automatic logic [3:0] exp_pxl(input logic [8:0] h, input logic [8:0] v);
    logic [12:0] ta;
    logic [21:0] wa;
    logic [31:0] tile;
    ta   = {v[7:3], h[7:3], v[2:0]};
    wa   = 22'(scr_start / 2) + 22'(ta) * 22'd2;
    tile = {model_word(wa + 22'd1), model_word(wa)};   // First word is the low half
    return tile[{h[2:0], 2'b00} +: 4];
endfunction

task automatic check_prog(input prog_t exp, input prog_t act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
    end
endtask

task automatic check_byte(input logic [7:0] exp, input logic [7:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
    end
endtask

task automatic check_pxl(input logic [3:0] exp, input logic [3:0] act);
    checks++;
    if (exp !== act) begin
        errors++;
        $display("CHECK FAILED %s: expected %h, actual %h", test_name, exp, act);
    end
endtask

task automatic check_count(input int exp, input int act);
    checks++;
    if (exp != act) begin
        errors++;
        $display("CHECK FAILED %s: expected %0d, actual %0d", test_name, exp, act);
    end
endtask

task automatic begin_test(input string name);
    test_name = name;
    test_base = errors;
    tests++;
endtask

task automatic end_test();
    $display("test %s finished with %0d errors", test_name, errors - test_base);
endtask

task automatic wait_main_ok();
    int n;
    n = 0;
    @(negedge clk);   // main_ok still shows the old address until this edge
    while (!main_ok && n < 60) begin
        @(negedge clk);
        n++;
    end
    if (!main_ok) begin
        errors++;
        $display("%s: main_ok did not rise within 60 cycles", test_name);
    end
endtask

task automatic test_reset();
    begin_test("reset");
    check_count(0, int'(sdram.req));
    check_count(0, int'(prog.we));
    check_count(0, int'(main_ok));
    check_count(0, int'(sync.hs));
    check_count(0, int'(sync.vs));
    check_count(0, int'(h_cnt));
    check_count(0, int'(v_cnt));
    end_test();
endtask

task automatic test_cen();
    int np;
    int n2;
    begin_test("cen");
    np = 0;
    n2 = 0;
    repeat (1000) begin
        @(negedge clk);
        np += int'(pxl_cen);
        n2 += int'(pxl2_cen);
    end
    check_count(128, np);
    check_count(64, n2);
    end_test();
endtask

task automatic test_download();
    logic [31:0] r;
    logic [24:0] a;
    int          acks;
    int          n;
    begin_test("download");
    downloading = 1'b1;
    for (int k = 0; k < 8; k++) begin
        rand_bits(15, r);
        a = (k < 4) ? {10'd0, r[14:0]} : scr_start + {11'd0, r[13:0]};   // Main region first
        rand_bits(8, r);
        ioctl_addr = a;
        ioctl_dout = r[7:0];
        ioctl_wr   = 1'b1;
        acks       = ack_count;
        @(negedge clk);
        ioctl_wr = 1'b0;
        check_prog(exp_prog(a, r[7:0]), prog);
        check_count(1, int'(dwnld_busy));
        n = 0;
        while (prog.we && n < 20) begin
            @(negedge clk);
            n++;
        end
        check_count(0, int'(prog.we));
        check_count(acks + 1, ack_count);   // Exactly one ack ended the write
    end
    downloading = 1'b0;
    @(negedge clk);
    check_count(0, int'(dwnld_busy));
    end_test();
endtask

task automatic test_main_read();
    logic [31:0] r;
    int          reqs;
    begin_test("main_read");
    main_cs = 1'b1;
    for (int k = 0; k < 6; k++) begin
        rand_bits(17, r);
        main_addr = r[16:0];
        wait_main_ok();
        check_byte(exp_byte(main_addr), main_data);
        reqs    = req_count;
        main_cs = 1'b0;
        @(negedge clk);
        main_cs = 1'b1;
        @(negedge clk);
        check_count(1, int'(main_ok));   // Hit answers one cycle later
        @(negedge clk);   // Model counts a request one edge after it sees it
        check_count(reqs, req_count);
    end
    main_cs = 1'b0;
    end_test();
endtask

task automatic test_download_block();
    logic [31:0] r;
    int          bad;
    begin_test("dl_block");
    rand_bits(17, r);
    downloading = 1'b1;
    @(negedge clk);
    main_cs   = 1'b1;
    main_addr = r[16:0];
    bad       = 0;
    repeat (30) begin
        @(negedge clk);
        bad += int'(main_ok || sdram.req);
    end
    check_count(0, bad);
    downloading = 1'b0;
    wait_main_ok();
    check_byte(exp_byte(main_addr), main_data);
    main_cs = 1'b0;
    end_test();
endtask

task automatic test_video();
    logic [8:0] last_h;
    int         seen;
    int         hs_first;
    int         hs_len;
    begin_test("video");
    main_cs = 1'b0;
    while (!(v_cnt == 9'(check_line) && h_cnt == 9'd0)) @(negedge clk);
    check_count(1, int'(sync.lvbl));   // Checked line is inside the visible lines
    seen     = 0;
    hs_first = -1;
    hs_len   = 0;
    last_h   = 9'h1ff;
    while (v_cnt == 9'(check_line)) begin
        if (h_cnt != last_h) begin
            if (sync.lhbl) begin
                check_pxl(exp_pxl(h_cnt, v_cnt), pxl);
                seen++;
            end
            if (sync.hs) begin
                if (hs_len == 0) hs_first = int'(h_cnt);
                hs_len++;
            end
        end
        last_h = h_cnt;
        @(negedge clk);
    end
    check_count(192, seen);   // Every visible pixel of the line
    check_count(208, hs_first);
    check_count(16, hs_len);   // Sync width in pixels
    end_test();
endtask

initial begin
    rst_n       = 1'b0;
    downloading = 1'b0;
    ioctl_addr  = '0;
    ioctl_dout  = '0;
    ioctl_wr    = 1'b0;
    main_cs     = 1'b0;
    main_addr   = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    test_reset();
    test_cen();
    test_download();
    test_main_read();
    test_download_block();
    test_video();
    errors += kicker_game_i.u_rom.arb_props.failures;
    errors += kicker_game_i.u_dwnld.dwnld_props.failures;
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
        $display("Result: PASSED");
    end else begin
        $display("Result: FAILED");
    end
    $finish;
end

// Most tests fit in the top blanking while the video test waits for a visible line
initial begin
    while (cycles < max_cycles) begin
        @(posedge clk);
        cycles++;
    end
    $display("Timeout: run did not finish within %0d cycles", max_cycles);
    $display("Result: FAILED");
    $finish;
end

endmodule

//--- source/frac_cen.sv
// Fractional clock-enable generator, n strobes every m clocks plus a half-rate strobe for video
module frac_cen #(
    parameter int n = 16,   // Strobes per period
    parameter int m = 125   // Period in clock cycles
) (
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,
    output logic pxl2_cen
);

localparam int aw = $clog2(n + m) + 1;

logic [aw-1:0] acc;
logic [aw-1:0] sum;
logic          over;
logic          half;   // Selects every second pxl_cen

assign sum  = acc + aw'(n);
assign over = sum >= aw'(m);

// Accumulator stays below m, so each window of m cycles overflows exactly n times
always_ff @(posedge clk) begin
    if (!rst_n) begin
        acc      <= '0;
        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
        half     <= 1'b0;
    end else begin
        acc      <= over ? sum - aw'(m) : sum;
        pxl_cen  <= over;
        pxl2_cen <= over && half;
        if (over) begin
            half <= ~half;
        end
    end
end

endmodule

//--- source/kicker_game.sv
// Top level of the trimmed kicker core, connects enables, ROM download, SDRAM arbiter and video
module kicker_game
    import kicker_pkg::*;
#(
    parameter int swab  = 1,
    parameter int cen_n = 16,    // Pixel clock is cen_n/cen_m of clk
    parameter int cen_m = 125
) (
    input  logic        clk,
    input  logic        rst_n,
    // Video
    output logic        pxl_cen,
    output logic        pxl2_cen,
    output logic [8:0]  h_cnt,
    output logic [8:0]  v_cnt,
    output video_sync_t sync,
    output logic [3:0]  pxl,        // Palette index
    // ROM download
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    output prog_t       prog,
    // Main CPU ROM port
    input  logic        main_cs,
    input  logic [16:0] main_addr,
    output logic [7:0]  main_data,
    output logic        main_ok,
    // SDRAM
    output sdram_rd_t   sdram,
    input  sdram_rsp_t  rsp
);

logic        scr_cs;
logic [12:0] scr_addr;
logic [31:0] scr_data;
logic        scr_ok;

frac_cen #(.n(cen_n), .m(cen_m)) u_cen (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .pxl_cen    ( pxl_cen   ),
    .pxl2_cen   ( pxl2_cen  )
);

rom_dwnld #(.swab(swab)) u_dwnld (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .downloading( downloading ),
    .ioctl_addr ( ioctl_addr  ),
    .ioctl_dout ( ioctl_dout  ),
    .ioctl_wr   ( ioctl_wr    ),
    .sdram_ack  ( rsp.ack     ),   // Shared with the read path
    .prog       ( prog        ),
    .dwnld_busy ( dwnld_busy  )
);

rom_arbiter u_rom (
    .clk        ( clk         ),
    .rst_n      ( rst_n       ),
    .downloading( downloading ),
    .scr_cs     ( scr_cs      ),
    .scr_addr   ( scr_addr    ),
    .scr_data   ( scr_data    ),
    .scr_ok     ( scr_ok      ),
    .main_cs    ( main_cs     ),
    .main_addr  ( main_addr   ),
    .main_data  ( main_data   ),
    .main_ok    ( main_ok     ),
    .sdram      ( sdram       ),
    .rsp        ( rsp         )
);

video_scroll u_video (
    .clk        ( clk       ),
    .rst_n      ( rst_n     ),
    .pxl_cen    ( pxl_cen   ),
    .h_cnt      ( h_cnt     ),
    .v_cnt      ( v_cnt     ),
    .sync       ( sync      ),
    .scr_cs     ( scr_cs    ),   // Active through the visible lines
    .scr_addr   ( scr_addr  ),
    .scr_data   ( scr_data  ),
    .scr_ok     ( scr_ok    ),
    .pxl        ( pxl       )
);

endmodule

//--- source/kicker_pkg.sv
// Shared constants, bus structs and FSM states of the kicker game core, imported by each block
package kicker_pkg;

    // SDRAM byte offsets
    parameter logic [24:0] scr_start  = 25'h08000;  // Scroll tile graphics
    parameter logic [24:0] main_start = 25'h00000;  // Main CPU ROM

    // Video timing, in pixels and lines
    parameter logic [8:0] h_total     = 9'd256;
    parameter logic [8:0] h_visible   = 9'd192;
    parameter logic [8:0] hs_start    = 9'd208;
    parameter logic [8:0] hs_end      = 9'd224;
    parameter logic [8:0] v_total     = 9'd264;
    parameter logic [8:0] v_vis_start = 9'd16;
    parameter logic [8:0] v_vis_end   = 9'd240;
    parameter logic [8:0] vs_start    = 9'd248;
    parameter logic [8:0] vs_end      = 9'd252;

    typedef struct packed {
        logic        req;   // Held until ack
        logic [21:0] addr;  // 16-bit word address
    } sdram_rd_t;

    typedef struct packed {
        logic        ack;   // Request taken, also ends a programming write
        logic        rdy;   // Read data valid
        logic [15:0] data;
    } sdram_rsp_t;

    typedef struct packed {
        logic        we;
        logic [21:0] addr;
        logic [7:0]  data;
        logic [1:0]  mask;  // Active low byte enables
    } prog_t;

    typedef struct packed {
        logic lhbl;  // Low during horizontal blanking
        logic lvbl;  // Low during vertical blanking
        logic hs;
        logic vs;
    } video_sync_t;

    typedef enum logic [1:0] {
        IDLE,
        REQ_LO,
        REQ_HI
    } arb_state_e;

endpackage

//--- source/rom_arbiter.sv
// SDRAM read arbiter for the scroll and main ROM slots, each with a one-entry hit cache
module rom_arbiter
    import kicker_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    // Slot 0, scroll tiles
    input  logic        scr_cs,
    input  logic [12:0] scr_addr,
    output logic [31:0] scr_data,
    output logic        scr_ok,
    // Slot 1, main CPU ROM
    input  logic        main_cs,
    input  logic [16:0] main_addr,
    output logic [7:0]  main_data,
    output logic        main_ok,
    // SDRAM
    output sdram_rd_t   sdram,
    input  sdram_rsp_t  rsp
);

localparam logic [21:0] scr_base  = scr_start[22:1];
localparam logic [21:0] main_base = main_start[22:1];

arb_state_e  state;
logic        cur_slot;   // Slot being served, 1 for main
logic        req_r;
logic [21:0] addr_r;

logic [12:0] scr_tag;
logic        scr_valid;
logic [31:0] scr_buf;
logic [16:0] main_tag;
logic        main_valid;
logic [15:0] main_word;

logic scr_miss;
logic main_miss;
logic start_scr;
logic start_main;
logic got_data;

assign scr_miss   = scr_cs && !(scr_valid && scr_tag == scr_addr);
assign main_miss  = main_cs && !(main_valid && main_tag == main_addr);
assign start_scr  = state == IDLE && !downloading && scr_miss;
assign start_main = state == IDLE && !downloading && !scr_miss && main_miss;
assign got_data   = state != IDLE && !req_r && rsp.rdy;   // Only after the ack

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state      <= IDLE;
        cur_slot   <= 1'b0;
        req_r      <= 1'b0;
        scr_valid  <= 1'b0;
        main_valid <= 1'b0;
        scr_ok     <= 1'b0;
        main_ok    <= 1'b0;
    end else begin
        scr_ok  <= scr_cs && scr_valid && scr_tag == scr_addr;
        main_ok <= main_cs && main_valid && main_tag == main_addr;
        case (state)
            IDLE: begin
                if (start_scr) begin
                    req_r     <= 1'b1;
                    cur_slot  <= 1'b0;
                    scr_valid <= 1'b0;
                    state     <= REQ_LO;
                end else if (start_main) begin
                    req_r      <= 1'b1;
                    cur_slot   <= 1'b1;
                    main_valid <= 1'b0;
                    state      <= REQ_LO;
                end
            end
            REQ_LO: begin
                if (req_r && rsp.ack) begin
                    req_r <= 1'b0;
                end else if (got_data) begin
                    if (cur_slot) begin
                        main_valid <= 1'b1;
                        state      <= IDLE;
                    end else begin
                        req_r <= 1'b1;   // Upper half of the tile word
                        state <= REQ_HI;
                    end
                end
            end
            REQ_HI: begin
                if (req_r && rsp.ack) begin
                    req_r <= 1'b0;
                end else if (got_data) begin
                    scr_valid <= 1'b1;
                    state     <= IDLE;
                end
            end
            default: state <= IDLE;
        endcase
        if (downloading) begin
            scr_valid  <= 1'b0;   // ROM contents are changing
            main_valid <= 1'b0;
        end
    end
end

always_ff @(posedge clk) begin
    if (start_scr) begin
        scr_tag <= scr_addr;
        addr_r  <= scr_base + {8'd0, scr_addr, 1'b0};
    end
    if (start_main) begin
        main_tag <= main_addr;
        addr_r   <= main_base + {6'd0, main_addr[16:1]};
    end
    if (got_data && state == REQ_LO && !cur_slot) begin
        scr_buf[15:0] <= rsp.data;
        addr_r        <= addr_r + 22'd1;
    end
    if (got_data && state == REQ_LO && cur_slot) begin
        main_word <= rsp.data;
    end
    if (got_data && state == REQ_HI) begin
        scr_buf[31:16] <= rsp.data;
    end
end

assign sdram     = '{req: req_r, addr: addr_r};
assign scr_data  = scr_buf;
assign main_data = main_addr[0] ? main_word[15:8] : main_word[7:0];

endmodule

//--- source/rom_dwnld.sv
// ROM download stage, turns the loader byte stream into SDRAM programming writes
module rom_dwnld
    import kicker_pkg::*;
#(
    parameter int swab = 0   // Swap the byte lane chosen by the address LSB
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [24:0] ioctl_addr,
    input  logic [7:0]  ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output prog_t       prog,
    output logic        dwnld_busy
);

localparam logic [24:0] scr_end = scr_start + 25'h04000;   // 16 kB of tiles

logic [21:0] word_addr;
logic [21:0] map_addr;
logic        in_scr;
logic        odd;
logic        wr_in;
logic        we_r;
logic [21:0] addr_r;
logic [7:0]  data_r;
logic [1:0]  mask_r;

assign word_addr = ioctl_addr[22:1];
assign in_scr    = ioctl_addr > scr_start && ioctl_addr < scr_end;
assign odd       = ioctl_addr[0] ^ (swab != 0);
assign wr_in     = downloading && ioctl_wr;

// Scroll tiles are stored with the line LSBs rotated so a tile row is one 32-bit pair
always_comb begin
    map_addr = word_addr;
    if (in_scr) begin
        map_addr[0]   = word_addr[3];
        map_addr[3:1] = word_addr[2:0];
    end
end

always_ff @(posedge clk) begin
    if (!rst_n) begin
        we_r <= 1'b0;
    end else if (wr_in) begin
        we_r <= 1'b1;
    end else if (sdram_ack) begin
        we_r <= 1'b0;   // SDRAM took the write
    end
end

always_ff @(posedge clk) begin
    if (wr_in) begin
        addr_r <= map_addr;
        data_r <= ioctl_dout;
        mask_r <= odd ? 2'b01 : 2'b10;   // Low bit enables the low byte
    end
end

assign prog       = '{we: we_r, addr: addr_r, data: data_r, mask: mask_r};
assign dwnld_busy = downloading;

endmodule

//--- source/video_scroll.sv
// Video timing and scroll layer, fetches one tile row ahead and outputs 4-bit pixel codes
module video_scroll
    import kicker_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        pxl_cen,
    output logic [8:0]  h_cnt,
    output logic [8:0]  v_cnt,
    output video_sync_t sync,
    output logic        scr_cs,
    output logic [12:0] scr_addr,
    input  logic [31:0] scr_data,
    input  logic        scr_ok,
    output logic [3:0]  pxl
);

logic [8:0]  h_nxt;
logic [8:0]  v_nxt;
logic [8:0]  fetch_v;
logic [4:0]  fetch_col;
logic        h_wrap;
logic        vis_nxt;
logic        boundary;
logic        fetch_new;   // scr_ok still refers to the previous address
logic [31:0] next_tile;
logic        next_rdy;
logic [31:0] tile_word;
logic        tile_rdy;
logic [31:0] pick_word;
logic        pick_rdy;

assign h_wrap = h_cnt == h_total - 9'd1;
assign h_nxt  = h_wrap ? 9'd0 : h_cnt + 9'd1;

always_comb begin
    v_nxt = v_cnt;
    if (h_wrap) begin
        v_nxt = v_cnt == v_total - 9'd1 ? 9'd0 : v_cnt + 9'd1;
    end
end

assign vis_nxt   = h_nxt < h_visible && v_nxt >= v_vis_start && v_nxt < v_vis_end;
assign boundary  = pxl_cen && h_nxt[2:0] == 3'd0;
assign fetch_col = h_nxt[7:3] + 5'd1;
assign fetch_v   = fetch_col == 5'd0 ? v_nxt + 9'd1 : v_nxt;   // Column 0 of the next line
assign pick_word = h_nxt[2:0] == 3'd0 ? next_tile : tile_word;
assign pick_rdy  = h_nxt[2:0] == 3'd0 ? next_rdy : tile_rdy;

assign sync = '{
    lhbl: h_cnt < h_visible,
    lvbl: v_cnt >= v_vis_start && v_cnt < v_vis_end,
    hs:   h_cnt >= hs_start && h_cnt < hs_end,
    vs:   v_cnt >= vs_start && v_cnt < vs_end
};
assign scr_cs = sync.lvbl;

always_ff @(posedge clk) begin
    if (!rst_n) begin
        h_cnt     <= 9'd0;
        v_cnt     <= 9'd0;
        scr_addr  <= 13'd0;
        fetch_new <= 1'b0;
        next_rdy  <= 1'b0;
        tile_rdy  <= 1'b0;
        pxl       <= 4'd0;
    end else begin
        fetch_new <= 1'b0;
        if (scr_ok && !fetch_new) next_rdy <= 1'b1;
        if (pxl_cen) begin
            h_cnt <= h_nxt;
            v_cnt <= v_nxt;
            pxl   <= vis_nxt && pick_rdy ? pick_word[{h_nxt[2:0], 2'b00} +: 4] : 4'd0;
            if (boundary) begin
                tile_rdy  <= next_rdy;
                next_rdy  <= 1'b0;
                scr_addr  <= {fetch_v[7:3], fetch_col, fetch_v[2:0]};
                fetch_new <= 1'b1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (scr_ok && !fetch_new) next_tile <= scr_data;
    if (boundary) tile_word <= next_tile;   // New column starts
end

endmodule
